/* common/excUnit_params.svh */
`ifndef EXC_UNIT_PARAMS_SVH
`define EXC_UNIT_PARAMS_SVH

// Wishbone byte address and data widths
`define EXC_WB_ADDR_W 4
`define EXC_WB_DATA_W 32

// Exception counter width, wraps at the top
`define EXC_COUNT_W 16

// Byte offsets of the control/status registers
`define EXC_REG_CTRL   4'h0
`define EXC_REG_STATUS 4'h4
`define EXC_REG_COUNT  4'h8

`endif

/* common/excPkg.sv */
`default_nettype none

package excPkg;

  // Exception kinds
  // Each encoding is also the vector index
  // Index 5 is unused by the vector table, so it marks "no exception"
  typedef enum logic [2:0] {
    excReset         = 3'd0,
    excUndef         = 3'd1,
    excSwi           = 3'd2,
    excPrefetchAbort = 3'd3,
    excDataAbort     = 3'd4,
    excNone          = 3'd5,
    excIrq           = 3'd6,
    excFiq           = 3'd7
  } excKind;

  // Processor modes, CPSR M[4:0] field values
  typedef enum logic [4:0] {
    modeUsr = 5'b10000,
    modeFiq = 5'b10001,
    modeIrq = 5'b10010,
    modeSvc = 5'b10011,
    modeAbt = 5'b10111,
    modeUnd = 5'b11011
  } armMode;

  // Control/status register selected by a bus access
  typedef enum logic [1:0] {
    regCtrl   = 2'd0,
    regStatus = 2'd1,
    regCount  = 2'd2
  } csrReg;

endpackage

`default_nettype wire

/* common/excCauseIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface excCauseIf import excPkg::*; ();

  // Highest ranked cause this cycle, reset not included
  excKind kind;
  // Data abort seen in M now, and the same abort one cycle on
  logic   dataAbortNow;
  logic   dataAbortCycle2;
  // Any cause raised in E
  logic   syncCauseE;
  // Enabled interrupt with nothing above it
  logic   intPending;
  // The pending interrupt is the FIQ
  logic   fiqSelected;

  modport decode (
    output kind, dataAbortNow, dataAbortCycle2, syncCauseE, intPending, fiqSelected
  );

  modport control (
    input kind, dataAbortNow, dataAbortCycle2, syncCauseE, intPending, fiqSelected
  );

  modport result (
    input kind, dataAbortNow, dataAbortCycle2, syncCauseE, intPending, fiqSelected
  );

endinterface

`default_nettype wire

/* exception/causeDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module causeDecode import excPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic undefE,
  input  logic swiE,
  input  logic prefetchAbortE,
  input  logic dataAbort,
  input  logic irq,
  input  logic fiq,
  input  logic irqEnable,
  input  logic fiqEnable,
  output logic undefM,
  output logic swiM,
  output logic prefetchAbortM,
  excCauseIf.decode cause
);

  logic dataAbortCycle2;
  logic irqEnSync;
  logic fiqEnSync;
  logic irqLive;
  logic fiqLive;
  logic higherCause;

  // E causes follow their instruction into M
  // The data abort is held one more cycle for vectoring
  always_ff @(posedge clk) begin
    if (!rstN) begin
      undefM          <= 1'b0;
      swiM            <= 1'b0;
      prefetchAbortM  <= 1'b0;
      dataAbortCycle2 <= 1'b0;
    end else begin
      undefM          <= undefE;
      swiM            <= swiE;
      prefetchAbortM  <= prefetchAbortE;
      dataAbortCycle2 <= dataAbort;
    end
  end

  // Enables come from the CSR block
  // One register stage, so a new enable acts a cycle after the bus ack
  always_ff @(posedge clk) begin
    if (!rstN) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnable;
      fiqEnSync <= fiqEnable;
    end
  end

  // Masked interrupt lines
  assign irqLive = irq & irqEnSync;
  assign fiqLive = fiq & fiqEnSync;

  // Aborts and E causes outrank both interrupts
  assign higherCause = dataAbort | dataAbortCycle2 | undefE | swiE | prefetchAbortE;

  // Priority encoder
  always_comb begin
    if (dataAbort || dataAbortCycle2)
      cause.kind = excDataAbort;
    else if (prefetchAbortE)
      cause.kind = excPrefetchAbort;
    else if (undefE)
      cause.kind = excUndef;
    else if (swiE)
      cause.kind = excSwi;
    else if (fiqLive)
      cause.kind = excFiq;
    else if (irqLive)
      cause.kind = excIrq;
    else
      cause.kind = excNone;
  end

  assign cause.dataAbortNow    = dataAbort;
  assign cause.dataAbortCycle2 = dataAbortCycle2;
  assign cause.syncCauseE      = undefE | swiE | prefetchAbortE;
  // FIQ wins when both lines are live
  assign cause.intPending      = ~higherCause & (fiqLive | irqLive);
  assign cause.fiqSelected     = ~higherCause & fiqLive;

endmodule

`default_nettype wire

/* exception/pipeClearControl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeClearControl (
  input  logic clk,
  input  logic rstN,
  input  logic hazardStall,
  excCauseIf.control cause,
  output logic clearF,
  output logic flushD,
  output logic flushE,
  output logic flushM,
  output logic flushW,
  output logic stallD,
  output logic resetMicrop,
  output logic irqAssert,
  output logic fiqAssert
);

  // Clear token position, one bit per stage past F
  logic tokenD;
  logic tokenE;
  logic tokenM;
  logic tokenKill;

  // Token enters F while an interrupt waits and none has reached M yet
  assign clearF = cause.intPending & ~tokenM;

  // Drop every token once the interrupt is raised
  // Also when no interrupt is pending, which covers a higher exception
  // or a line that went away before the token arrived
  assign tokenKill = ~cause.intPending | tokenM;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tokenD <= 1'b0;
      tokenE <= 1'b0;
      tokenM <= 1'b0;
    end else if (tokenKill) begin
      tokenD <= 1'b0;
      tokenE <= 1'b0;
      tokenM <= 1'b0;
    end else begin
      // Hazard stall freezes F and D, so the token sits in D
      // and a bubble goes on into E
      if (!hazardStall)
        tokenD <= clearF;
      tokenE <= tokenD & ~hazardStall;
      tokenM <= tokenE;
    end
  end

  always_comb begin
    flushD    = 1'b0;
    flushE    = 1'b0;
    flushM    = 1'b0;
    flushW    = 1'b0;
    stallD    = 1'b0;
    irqAssert = 1'b0;
    fiqAssert = 1'b0;
    if (cause.dataAbortNow || cause.dataAbortCycle2) begin
      // Abort caught in M
      // First cycle stalls D and kills E too
      // Second cycle vectors and flushes D
      flushD = 1'b1;
      flushE = cause.dataAbortNow;
      flushM = 1'b1;
      flushW = 1'b1;
      stallD = cause.dataAbortNow;
    end else if (cause.syncCauseE) begin
      // Caught in E
      // Younger work in D goes, the faulting op becomes a bubble in M
      flushD = 1'b1;
      flushM = 1'b1;
    end else if (cause.intPending) begin
      // Squash younger instructions while the token drains
      flushE = tokenD & ~tokenM;
      stallD = tokenD & ~tokenM;
      // Token in M means all older work has retired
      flushD    = tokenM;
      irqAssert = tokenM & ~cause.fiqSelected;
      fiqAssert = tokenM & cause.fiqSelected;
    end
  end

  // Micro-op sequence restarts on the first abort cycle
  assign resetMicrop = cause.dataAbortNow;

endmodule

`default_nettype wire

/* exception/vectorResult.sv */
`timescale 1ns/1ps
`default_nettype none

module vectorResult import excPkg::*; (
  input  logic       rstN,
  input  logic       irqAssert,
  input  logic       fiqAssert,
  excCauseIf.result  cause,
  output logic [2:0] vectorIndex,
  output logic       savePc,
  output logic [1:0] pcInSelect,
  output armMode     newMode,
  output excKind     takenKind
);

  // Kind actually vectored this cycle
  // First data abort cycle only stalls, the vector comes a cycle later
  always_comb begin
    if (!rstN)
      takenKind = excReset;
    else if (cause.dataAbortCycle2)
      takenKind = excDataAbort;
    else if (cause.syncCauseE && !cause.dataAbortNow)
      takenKind = cause.kind;
    else if (fiqAssert)
      takenKind = excFiq;
    else if (irqAssert)
      takenKind = excIrq;
    else
      takenKind = excNone;
  end

  assign savePc      = (takenKind != excNone);
  // Kind encoding is the vector table slot
  assign vectorIndex = takenKind;

  // Return address to save
  always_comb begin
    case (takenKind)
      excIrq, excFiq:
        pcInSelect = 2'b10; // PCD + 4
      excUndef, excSwi, excPrefetchAbort, excDataAbort:
        pcInSelect = 2'b01; // PCD
      default:
        pcInSelect = 2'b00; // PCD + 8
    endcase
  end

  // Mode to enter
  always_comb begin
    case (takenKind)
      excReset, excSwi:               newMode = modeSvc;
      excUndef:                       newMode = modeUnd;
      excPrefetchAbort, excDataAbort: newMode = modeAbt;
      excIrq:                         newMode = modeIrq;
      excFiq:                         newMode = modeFiq;
      default:                        newMode = modeUsr;
    endcase
  end

endmodule

`default_nettype wire

/* logic/excCsr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excUnit_params.svh"

module excCsr import excPkg::*; (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      wbCyc,
  input  logic                      wbStb,
  input  logic                      wbWe,
  input  logic [`EXC_WB_ADDR_W-1:0] wbAdr,
  input  logic [`EXC_WB_DATA_W-1:0] wbDatWr,
  input  logic                      excTaken,
  input  excKind                    takenKind,
  output logic [`EXC_WB_DATA_W-1:0] wbDatRd,
  output logic                      wbAck,
  output logic                      irqEnable,
  output logic                      fiqEnable
);

  logic [1:0]              ctrlReg;
  excKind                  lastKind;
  logic [`EXC_COUNT_W-1:0] excCount;
  csrReg                   regSel;
  logic                    regHit;
  logic                    busReq;
  logic                    busWrite;
  logic                    countInc;

  // Offset decode
  always_comb begin
    regSel = regCtrl;
    regHit = 1'b1;
    case (wbAdr)
      `EXC_REG_CTRL:   regSel = regCtrl;
      `EXC_REG_STATUS: regSel = regStatus;
      `EXC_REG_COUNT:  regSel = regCount;
      default:         regHit = 1'b0;
    endcase
  end

  // New request, ack still low
  assign busReq   = wbCyc & wbStb & ~wbAck;
  assign busWrite = busReq & wbWe;

  // One ack per request, master holds its signals until then
  always_ff @(posedge clk) begin
    if (!rstN)
      wbAck <= 1'b0;
    else
      wbAck <= busReq;
  end

  // Enables, bit 0 IRQ, bit 1 FIQ
  always_ff @(posedge clk) begin
    if (!rstN)
      ctrlReg <= 2'b00;
    else if (busWrite && regHit && regSel == regCtrl)
      ctrlReg <= wbDatWr[1:0];
  end

  // Reset vectoring is not bookkeeping
  assign countInc = excTaken & (takenKind != excReset);

  // Status is read only, it tracks the hardware
  always_ff @(posedge clk) begin
    if (!rstN)
      lastKind <= excNone;
    else if (countInc)
      lastKind <= takenKind;
  end

  // Any write clears, otherwise count up and wrap
  always_ff @(posedge clk) begin
    if (!rstN)
      excCount <= '0;
    else if (busWrite && regHit && regSel == regCount)
      excCount <= '0;
    else if (countInc)
      excCount <= excCount + 1'b1;
  end

  // Read data, zero for unmapped offsets
  always_comb begin
    wbDatRd = '0;
    if (regHit) begin
      case (regSel)
        regCtrl:   wbDatRd[1:0] = ctrlReg;
        regStatus: wbDatRd[2:0] = lastKind;
        regCount:  wbDatRd[`EXC_COUNT_W-1:0] = excCount;
        default:   wbDatRd = '0;
      endcase
    end
  end

  assign irqEnable = ctrlReg[0];
  assign fiqEnable = ctrlReg[1];

endmodule

`default_nettype wire

/* logic/excUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excUnit_params.svh"

module excUnit import excPkg::*; (
  input  logic                      clk,
  input  logic                      rstN,
  // Pipeline causes
  input  logic                      undefE,
  input  logic                      swiE,
  input  logic                      prefetchAbortE,
  input  logic                      dataAbort,
  input  logic                      irq,
  input  logic                      fiq,
  input  logic                      hazardStall,
  // Causes carried into M
  output logic                      undefM,
  output logic                      swiM,
  output logic                      prefetchAbortM,
  output logic                      dataAbortCycle2,
  // Pipeline control
  output logic                      clearF,
  output logic                      flushD,
  output logic                      flushE,
  output logic                      flushM,
  output logic                      flushW,
  output logic                      stallD,
  output logic                      resetMicrop,
  output logic                      irqAssert,
  output logic                      fiqAssert,
  // Vectoring
  output logic [2:0]                vectorIndex,
  output logic                      savePc,
  output logic [1:0]                pcInSelect,
  output armMode                    newMode,
  // Wishbone classic slave
  input  logic                      wbCyc,
  input  logic                      wbStb,
  input  logic                      wbWe,
  input  logic [`EXC_WB_ADDR_W-1:0] wbAdr,
  input  logic [`EXC_WB_DATA_W-1:0] wbDatWr,
  output logic [`EXC_WB_DATA_W-1:0] wbDatRd,
  output logic                      wbAck
);

  logic   irqEnable;
  logic   fiqEnable;
  excKind takenKind;

  excCauseIf cause ();

  causeDecode uDecode (
    .clk            (clk),
    .rstN           (rstN),
    .undefE         (undefE),
    .swiE           (swiE),
    .prefetchAbortE (prefetchAbortE),
    .dataAbort      (dataAbort),
    .irq            (irq),
    .fiq            (fiq),
    .irqEnable      (irqEnable),
    .fiqEnable      (fiqEnable),
    .undefM         (undefM),
    .swiM           (swiM),
    .prefetchAbortM (prefetchAbortM),
    .cause          (cause.decode)
  );

  pipeClearControl uControl (
    .clk         (clk),
    .rstN        (rstN),
    .hazardStall (hazardStall),
    .cause       (cause.control),
    .clearF      (clearF),
    .flushD      (flushD),
    .flushE      (flushE),
    .flushM      (flushM),
    .flushW      (flushW),
    .stallD      (stallD),
    .resetMicrop (resetMicrop),
    .irqAssert   (irqAssert),
    .fiqAssert   (fiqAssert)
  );

  vectorResult uResult (
    .rstN        (rstN),
    .irqAssert   (irqAssert),
    .fiqAssert   (fiqAssert),
    .cause       (cause.result),
    .vectorIndex (vectorIndex),
    .savePc      (savePc),
    .pcInSelect  (pcInSelect),
    .newMode     (newMode),
    .takenKind   (takenKind)
  );

  // Every vectored exception is logged
  excCsr uCsr (
    .clk       (clk),
    .rstN      (rstN),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatWr   (wbDatWr),
    .excTaken  (savePc),
    .takenKind (takenKind),
    .wbDatRd   (wbDatRd),
    .wbAck     (wbAck),
    .irqEnable (irqEnable),
    .fiqEnable (fiqEnable)
  );

  // Delayed abort doubles as the abort flag for the rest of the core
  assign dataAbortCycle2 = cause.dataAbortCycle2;

endmodule

`default_nettype wire

/* test/excUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excUnit_params.svh"

module excUnitTb import excPkg::*; ();

  localparam int rowTotal = 9;

  logic clk;
  logic rstN;
  logic undefE;
  logic swiE;
  logic prefetchAbortE;
  logic dataAbort;
  logic irq;
  logic fiq;
  logic hazardStall;
  logic undefM;
  logic swiM;
  logic prefetchAbortM;
  logic dataAbortCycle2;
  logic clearF;
  logic flushD;
  logic flushE;
  logic flushM;
  logic flushW;
  logic stallD;
  logic resetMicrop;
  logic irqAssert;
  logic fiqAssert;
  logic [2:0] vectorIndex;
  logic savePc;
  logic [1:0] pcInSelect;
  armMode newMode;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [`EXC_WB_ADDR_W-1:0] wbAdr;
  logic [`EXC_WB_DATA_W-1:0] wbDatWr;
  logic [`EXC_WB_DATA_W-1:0] wbDatRd;
  logic wbAck;

  int errorCount;
  int checkCount;
  int rowFill;
  int expCount;
  excKind expLast;
  logic [31:0] rngState;
  logic [31:0] rdData;

  // Stimulus table
  // stim bits are prefetchAbortE, undefE, swiE, dataAbort, fiq, irq
  // en bits are fiqEnable, irqEnable
  // ctl bits are flushD, flushE, flushM, flushW, stallD, clearF, savePc, resetMicrop
  string       rowName [rowTotal];
  logic [5:0]  rowStim [rowTotal];
  logic [1:0]  rowEn [rowTotal];
  logic [7:0]  rowCtl [rowTotal];
  logic [2:0]  rowVec [rowTotal];
  logic [1:0]  rowSel [rowTotal];
  armMode      rowMode [rowTotal];
  excKind      rowLast [rowTotal];

  excUnit dut (
    .clk             (clk),
    .rstN            (rstN),
    .undefE          (undefE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .hazardStall     (hazardStall),
    .undefM          (undefM),
    .swiM            (swiM),
    .prefetchAbortM  (prefetchAbortM),
    .dataAbortCycle2 (dataAbortCycle2),
    .clearF          (clearF),
    .flushD          (flushD),
    .flushE          (flushE),
    .flushM          (flushM),
    .flushW          (flushW),
    .stallD          (stallD),
    .resetMicrop     (resetMicrop),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert),
    .vectorIndex     (vectorIndex),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect),
    .newMode         (newMode),
    .wbCyc           (wbCyc),
    .wbStb           (wbStb),
    .wbWe            (wbWe),
    .wbAdr           (wbAdr),
    .wbDatWr         (wbDatWr),
    .wbDatRd         (wbDatRd),
    .wbAck           (wbAck)
  );

  // 100 ns period
  always #50 clk = ~clk;

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    begin
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
    end
  endfunction

  task automatic expectEq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    begin
      checkCount++;
      if (actual !== expected) begin
        errorCount++;
        $display("FAILED %s: expected %0h, actual %0h", what, expected, actual);
      end
    end
  endtask

  task automatic addRow(input string name, input logic [5:0] stim, input logic [1:0] en,
                        input logic [7:0] ctl, input logic [2:0] vec, input logic [1:0] sel,
                        input armMode mode, input excKind last);
    begin
      rowName[rowFill] = name;
      rowStim[rowFill] = stim;
      rowEn[rowFill]   = en;
      rowCtl[rowFill]  = ctl;
      rowVec[rowFill]  = vec;
      rowSel[rowFill]  = sel;
      rowMode[rowFill] = mode;
      rowLast[rowFill] = last;
      rowFill++;
    end
  endtask

  task automatic driveIdle();
    begin
      undefE         = 1'b0;
      swiE           = 1'b0;
      prefetchAbortE = 1'b0;
      dataAbort      = 1'b0;
      irq            = 1'b0;
      fiq            = 1'b0;
      hazardStall    = 1'b0;
    end
  endtask

  task automatic idleCycles(input int n);
    begin
      repeat (n) @(posedge clk);
    end
  endtask

  // Wishbone classic single access
  // Master holds its signals until ack
  task automatic busAccess(input logic write, input logic [`EXC_WB_ADDR_W-1:0] addr,
                           input logic [31:0] data, output logic [31:0] readBack);
    int waitCycles;
    logic got;
    begin
      readBack = '0;
      @(posedge clk);
      #5;
      wbCyc   = 1'b1;
      wbStb   = 1'b1;
      wbWe    = write;
      wbAdr   = addr;
      wbDatWr = data;
      got = 1'b0;
      waitCycles = 0;
      while (!got && waitCycles < 20) begin
        @(negedge clk);
        waitCycles++;
        if (wbAck) begin
          got = 1'b1;
          readBack = wbDatRd;
        end
      end
      if (!got) begin
        errorCount++;
        $display("Wishbone access at offset %0h got no ack within 20 cycles", addr);
      end
      @(posedge clk);
      #5;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
      // Ack lasts a single cycle
      @(negedge clk);
      expectEq("wbAck after access", 0, wbAck);
    end
  endtask

  task automatic writeReg(input logic [`EXC_WB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    begin
      busAccess(1'b1, addr, data, unused);
    end
  endtask

  task automatic readReg(input logic [`EXC_WB_ADDR_W-1:0] addr, output logic [31:0] data);
    begin
      busAccess(1'b0, addr, 32'h0, data);
    end
  endtask

  task automatic runRow(input int i);
    logic [5:0] s;
    logic [7:0] c;
    begin
      s = rowStim[i];
      c = rowCtl[i];
      writeReg(`EXC_REG_CTRL, {30'b0, rowEn[i]});
      // Enable passes the sync stage
      idleCycles(2);
      @(posedge clk);
      #5;
      prefetchAbortE = s[5];
      undefE         = s[4];
      swiE           = s[3];
      dataAbort      = s[2];
      fiq            = s[1];
      irq            = s[0];
      @(negedge clk);
      expectEq({rowName[i], " flushD"}, c[7], flushD);
      expectEq({rowName[i], " flushE"}, c[6], flushE);
      expectEq({rowName[i], " flushM"}, c[5], flushM);
      expectEq({rowName[i], " flushW"}, c[4], flushW);
      expectEq({rowName[i], " stallD"}, c[3], stallD);
      expectEq({rowName[i], " clearF"}, c[2], clearF);
      expectEq({rowName[i], " savePc"}, c[1], savePc);
      expectEq({rowName[i], " resetMicrop"}, c[0], resetMicrop);
      expectEq({rowName[i], " vectorIndex"}, rowVec[i], vectorIndex);
      expectEq({rowName[i], " pcInSelect"}, rowSel[i], pcInSelect);
      expectEq({rowName[i], " newMode"}, rowMode[i], newMode);
      // Causes reach M one cycle later
      @(posedge clk);
      #5;
      driveIdle();
      @(negedge clk);
      expectEq({rowName[i], " prefetchAbortM"}, s[5], prefetchAbortM);
      expectEq({rowName[i], " undefM"}, s[4], undefM);
      expectEq({rowName[i], " swiM"}, s[3], swiM);
      expectEq({rowName[i], " dataAbortCycle2"}, s[2], dataAbortCycle2);
      if (s[2]) begin
        // Second abort cycle vectors
        expectEq({rowName[i], " cycle2 vectorIndex"}, 4, vectorIndex);
        expectEq({rowName[i], " cycle2 newMode"}, modeAbt, newMode);
        expectEq({rowName[i], " cycle2 flushE"}, 0, flushE);
        expectEq({rowName[i], " cycle2 stallD"}, 0, stallD);
        expectEq({rowName[i], " cycle2 savePc"}, 1, savePc);
        expectEq({rowName[i], " cycle2 pcInSelect"}, 1, pcInSelect);
      end
      if (rowLast[i] != excNone) begin
        expCount++;
        expLast = rowLast[i];
      end
    end
  endtask

  // Raise a line and let the clear token travel under random stalls
  task automatic takeInterrupt(input string tname, input logic lineIrq, input logic lineFiq,
                               input logic [1:0] en, input logic wantFiq);
    int waitCycles;
    int tokenPos;
    logic stallNow;
    logic seen;
    begin
      writeReg(`EXC_REG_CTRL, {30'b0, en});
      idleCycles(2);
      @(posedge clk);
      #5;
      irq         = lineIrq;
      fiq         = lineFiq;
      hazardStall = 1'b0;
      @(negedge clk);
      expectEq({tname, " clearF first cycle"}, 1, clearF);
      expectEq({tname, " assert first cycle"}, 0, irqAssert | fiqAssert);
      // Token now heads for D
      tokenPos = 1;
      seen = 1'b0;
      waitCycles = 0;
      while (!seen && waitCycles < 40) begin
        @(posedge clk);
        #5;
        rngState = nextRandom(rngState);
        stallNow = (rngState[1:0] == 2'b00);
        hazardStall = stallNow;
        @(negedge clk);
        waitCycles++;
        expectEq({tname, " assert timing"}, (tokenPos == 3), irqAssert | fiqAssert);
        if (irqAssert || fiqAssert)
          seen = 1'b1;
        // Token holds in D under a hazard stall
        if (!(tokenPos == 1 && stallNow))
          tokenPos++;
      end
      if (!seen) begin
        errorCount++;
        $display("%s: no interrupt assert within 40 cycles", tname);
      end else begin
        expectEq({tname, " irqAssert"}, !wantFiq, irqAssert);
        expectEq({tname, " fiqAssert"}, wantFiq, fiqAssert);
        expectEq({tname, " pcInSelect"}, 2, pcInSelect);
        expectEq({tname, " vectorIndex"}, wantFiq ? 7 : 6, vectorIndex);
        expectEq({tname, " flushD"}, 1, flushD);
        expectEq({tname, " savePc"}, 1, savePc);
        expectEq({tname, " newMode"}, wantFiq ? modeFiq : modeIrq, newMode);
        expCount++;
        expLast = wantFiq ? excFiq : excIrq;
      end
      // Source stays high one more cycle
      @(posedge clk);
      #5;
      hazardStall = 1'b0;
      @(negedge clk);
      // Assert lasts a single cycle
      expectEq({tname, " single assert cycle"}, 0, irqAssert | fiqAssert);
      // Handler clears the source
      @(posedge clk);
      #5;
      driveIdle();
      repeat (4) begin
        @(negedge clk);
        expectEq({tname, " clearF after"}, 0, clearF);
        expectEq({tname, " assert after"}, 0, irqAssert | fiqAssert);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    wbCyc      = 1'b0;
    wbStb      = 1'b0;
    wbWe       = 1'b0;
    wbAdr      = '0;
    wbDatWr    = '0;
    errorCount = 0;
    checkCount = 0;
    rowFill    = 0;
    expCount   = 0;
    expLast    = excNone;
    rngState   = 32'h4f6671b3;
    driveIdle();

    addRow("undef", 6'b010000, 2'b00, 8'b1010_0010, 3'd1, 2'd1, modeUnd, excUndef);
    addRow("swi", 6'b001000, 2'b00, 8'b1010_0010, 3'd2, 2'd1, modeSvc, excSwi);
    addRow("prefetchAbort", 6'b100000, 2'b00, 8'b1010_0010, 3'd3, 2'd1, modeAbt,
           excPrefetchAbort);
    addRow("undefOverSwi", 6'b011000, 2'b00, 8'b1010_0010, 3'd1, 2'd1, modeUnd, excUndef);
    addRow("prefetchOverAll", 6'b111000, 2'b00, 8'b1010_0010, 3'd3, 2'd1, modeAbt,
           excPrefetchAbort);
    addRow("swiOverFiq", 6'b001010, 2'b10, 8'b1010_0010, 3'd2, 2'd1, modeSvc, excSwi);
    // IRQ line with only the FIQ enable set
    addRow("irqMasked", 6'b000001, 2'b10, 8'b0000_0000, 3'd5, 2'd0, modeUsr, excNone);
    addRow("dataAbort", 6'b000100, 2'b00, 8'b1111_1001, 3'd5, 2'd0, modeUsr, excDataAbort);
    addRow("dataAbortOverAll", 6'b010111, 2'b11, 8'b1111_1001, 3'd5, 2'd0, modeUsr,
           excDataAbort);

    // Vector outputs during reset
    repeat (7) begin
      @(negedge clk);
      expectEq("reset savePc", 1, savePc);
      expectEq("reset vectorIndex", 0, vectorIndex);
      expectEq("reset newMode", modeSvc, newMode);
    end
    @(posedge clk);
    #5;
    rstN = 1'b1;
    @(negedge clk);
    expectEq("idle flushes", 4'b0000, {flushD, flushE, flushM, flushW});
    expectEq("idle stallD", 0, stallD);
    expectEq("idle clearF", 0, clearF);
    expectEq("idle resetMicrop", 0, resetMicrop);
    expectEq("idle asserts", 2'b00, {irqAssert, fiqAssert});
    expectEq("idle savePc", 0, savePc);
    expectEq("idle wbAck", 0, wbAck);
    readReg(`EXC_REG_CTRL, rdData);
    expectEq("ctrl after reset", 0, rdData);
    readReg(`EXC_REG_COUNT, rdData);
    expectEq("count after reset", 0, rdData);

    for (int i = 0; i < rowTotal; i++)
      runRow(i);

    takeInterrupt("irqTaken", 1'b1, 1'b0, 2'b01, 1'b0);
    takeInterrupt("fiqTaken", 1'b0, 1'b1, 2'b10, 1'b1);
    takeInterrupt("fiqOverIrq", 1'b1, 1'b1, 2'b11, 1'b1);

    // Bookkeeping registers
    readReg(`EXC_REG_STATUS, rdData);
    expectEq("status last kind", {29'b0, expLast}, rdData);
    readReg(`EXC_REG_COUNT, rdData);
    expectEq("count of exceptions", expCount, rdData);
    writeReg(`EXC_REG_COUNT, 32'h0000_a5a5);
    readReg(`EXC_REG_COUNT, rdData);
    expectEq("count after clear", 0, rdData);
    readReg(`EXC_REG_STATUS, rdData);
    expectEq("status after clear", {29'b0, expLast}, rdData);

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* excUnit.f */
+incdir+common
common/excPkg.sv
common/excCauseIf.sv
exception/causeDecode.sv
exception/pipeClearControl.sv
exception/vectorResult.sv
logic/excCsr.sv
logic/excUnit.sv
test/excUnitTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the excUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module excUnitTb \
  -f excUnit.f -Mdir obj_dir -o excUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/excUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi

exit 0
